/* src/be_config.svh */
`ifndef BE_CONFIG_SVH
`define BE_CONFIG_SVH

// Width of the one-hot ALU op vector
`define BE_ALU_OPS  12

`define BE_XLEN     32  // Data and address width
`define BE_RADDR_W  5   // Register file address width

// Data SRAM depth as log2 of words
`define BE_DSRAM_AW 8

`endif

/* src/be_pkg.sv */
`include "be_config.svh"

package be_pkg;

    // Bit positions within the one-hot op vector
    typedef enum int unsigned {
        OP_ADD  = 0,
        OP_SUB  = 1,
        OP_SLT  = 2,
        OP_SLTU = 3,
        OP_AND  = 4,
        OP_NOR  = 5,
        OP_OR   = 6,
        OP_XOR  = 7,
        OP_SLL  = 8,
        OP_SRL  = 9,
        OP_SRA  = 10,
        OP_LUI  = 11
    } alu_op_e;

    typedef logic [`BE_ALU_OPS-1:0] alu_op_t;

    // Decoded instruction from the issue side, 148 bits
    typedef struct packed {
        alu_op_t                alu_op;
        logic                   res_from_mem;   // Load
        logic [`BE_XLEN-1:0]    src1;
        logic [`BE_XLEN-1:0]    src2;
        logic                   mem_we;         // Store
        logic                   rf_we;
        logic [`BE_RADDR_W-1:0] rf_waddr;
        logic [`BE_XLEN-1:0]    rkd_value;      // Store data
        logic [`BE_XLEN-1:0]    pc;
    } issue_t;

    typedef struct packed {
        logic                   res_from_mem;
        logic                   rf_we;
        logic [`BE_RADDR_W-1:0] rf_waddr;
        logic [`BE_XLEN-1:0]    alu_result;
        logic [`BE_XLEN-1:0]    pc;
    } ex_mem_t;

    typedef struct packed {
        logic                   rf_we;
        logic [`BE_RADDR_W-1:0] rf_waddr;
        logic [`BE_XLEN-1:0]    rf_wdata;
        logic [`BE_XLEN-1:0]    pc;
    } mem_wb_t;

endpackage

/* src/ex_mem_if.sv */
`timescale 1ns/1ps

interface ex_mem_if;

    logic            valid;
    logic            allowin;   // From memory stage
    be_pkg::ex_mem_t data;

    modport master (
        output valid,
        output data,
        input  allowin
    );

    modport slave (
        input  valid,
        input  data,
        output allowin
    );

endinterface

/* src/mem_wb_if.sv */
`timescale 1ns/1ps

interface mem_wb_if;

    logic            valid;
    logic            allowin;   // From writeback stage
    be_pkg::mem_wb_t data;

    modport master (
        output valid,
        output data,
        input  allowin
    );

    modport slave (
        input  valid,
        input  data,
        output allowin
    );

endinterface

/* src/dsram_if.sv */
`timescale 1ns/1ps
`include "be_config.svh"

interface dsram_if;

    logic                    en;
    logic                    we;
    logic [`BE_DSRAM_AW-1:0] addr;     // Word address
    logic [`BE_XLEN-1:0]     wdata;
    logic [`BE_XLEN-1:0]     rdata;    // Valid the cycle after a load request

    modport request (output en, output we, output addr, output wdata);

    modport memory (input en, input we, input addr, input wdata, output rdata);

    modport rd (input rdata);

endinterface

/* src/alu.sv */
`timescale 1ns/1ps
`include "be_config.svh"

module alu (
    input  be_pkg::alu_op_t     alu_op,
    input  logic [`BE_XLEN-1:0] alu_src1,
    input  logic [`BE_XLEN-1:0] alu_src2,
    output logic [`BE_XLEN-1:0] alu_result
);

    localparam int XLEN = `BE_XLEN;
    localparam int SHW  = $clog2(`BE_XLEN);

    logic            op_sub;
    logic [XLEN-1:0] adder_b;
    logic [XLEN-1:0] adder_sum;
    logic            adder_cout;
    logic            slt_bit;
    logic            sltu_bit;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;

    // SUB, SLT and SLTU all subtract
    assign op_sub = alu_op[be_pkg::OP_SUB] | alu_op[be_pkg::OP_SLT] | alu_op[be_pkg::OP_SLTU];

    assign adder_b = op_sub ? ~alu_src2 : alu_src2;
    assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {{XLEN{1'b0}}, op_sub};

    // Signed less-than from sign bits and difference sign
    assign slt_bit  = (alu_src1[XLEN-1] & ~alu_src2[XLEN-1])
                    | (~(alu_src1[XLEN-1] ^ alu_src2[XLEN-1]) & adder_sum[XLEN-1]);
    assign sltu_bit = ~adder_cout;   // Borrow out

    assign shamt   = alu_src2[SHW-1:0];
    assign sll_res = alu_src1 << shamt;
    assign srl_res = alu_src1 >> shamt;
    assign sra_res = $signed(alu_src1) >>> shamt;

    assign alu_result =
          ({XLEN{alu_op[be_pkg::OP_ADD] | alu_op[be_pkg::OP_SUB]}} & adder_sum)
        | ({XLEN{alu_op[be_pkg::OP_SLT]}}  & {{(XLEN-1){1'b0}}, slt_bit})
        | ({XLEN{alu_op[be_pkg::OP_SLTU]}} & {{(XLEN-1){1'b0}}, sltu_bit})
        | ({XLEN{alu_op[be_pkg::OP_AND]}}  & (alu_src1 & alu_src2))
        | ({XLEN{alu_op[be_pkg::OP_NOR]}}  & ~(alu_src1 | alu_src2))
        | ({XLEN{alu_op[be_pkg::OP_OR]}}   & (alu_src1 | alu_src2))
        | ({XLEN{alu_op[be_pkg::OP_XOR]}}  & (alu_src1 ^ alu_src2))
        | ({XLEN{alu_op[be_pkg::OP_SLL]}}  & sll_res)
        | ({XLEN{alu_op[be_pkg::OP_SRL]}}  & srl_res)
        | ({XLEN{alu_op[be_pkg::OP_SRA]}}  & sra_res)
        | ({XLEN{alu_op[be_pkg::OP_LUI]}}  & alu_src2);   // Immediate already shifted

endmodule

/* src/ex_stage.sv */
`timescale 1ns/1ps
`include "be_config.svh"

module ex_stage (
    input  logic            clk,
    input  logic            resetn,

    input  logic            in_valid,
    output logic            in_allowin,
    input  be_pkg::issue_t  in_bus,

    ex_mem_if.master        ex_mem,
    dsram_if.request        dsram
);

    logic                ex_valid;
    logic                ex_fire;
    be_pkg::issue_t      ex_bus;
    logic [`BE_XLEN-1:0] ex_alu_result;

    assign in_allowin = ~ex_valid | ex_mem.allowin;   // Single-cycle execute

    // Item leaves execute at this edge
    assign ex_fire = ex_valid & ex_mem.allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_bus <= in_bus;
        end
    end

    alu i_alu (
        .alu_op     (ex_bus.alu_op),
        .alu_src1   (ex_bus.src1),
        .alu_src2   (ex_bus.src2),
        .alu_result (ex_alu_result)
    );

    assign ex_mem.valid             = ex_valid;
    assign ex_mem.data.res_from_mem = ex_bus.res_from_mem;
    assign ex_mem.data.rf_we        = ex_bus.rf_we & ex_valid;
    assign ex_mem.data.rf_waddr     = ex_bus.rf_waddr;
    assign ex_mem.data.alu_result   = ex_alu_result;
    assign ex_mem.data.pc           = ex_bus.pc;

    // Request only at the transfer so a stall never re-reads the RAM
    assign dsram.en    = ex_fire & (ex_bus.res_from_mem | ex_bus.mem_we);
    assign dsram.we    = ex_fire & ex_bus.mem_we;
    assign dsram.addr  = ex_alu_result[`BE_DSRAM_AW+1:2];   // Word index
    assign dsram.wdata = ex_bus.rkd_value;

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic     clk,
    input  logic     resetn,

    ex_mem_if.slave  ex_mem,
    dsram_if.rd      dsram,
    mem_wb_if.master mem_wb
);

    logic            mem_valid;
    be_pkg::ex_mem_t mem_bus;

    // Load data already registered in the RAM
    assign ex_mem.allowin = ~mem_valid | mem_wb.allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (ex_mem.allowin) begin
            mem_valid <= ex_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.allowin) begin
            mem_bus <= ex_mem.data;
        end
    end

    assign mem_wb.valid         = mem_valid;
    assign mem_wb.data.rf_we    = mem_bus.rf_we & mem_valid;
    assign mem_wb.data.rf_waddr = mem_bus.rf_waddr;
    assign mem_wb.data.rf_wdata = mem_bus.res_from_mem ? dsram.rdata : mem_bus.alu_result;
    assign mem_wb.data.pc       = mem_bus.pc;

endmodule

/* src/wb_stage.sv */
`timescale 1ns/1ps
`include "be_config.svh"

module wb_stage (
    input  logic                   clk,
    input  logic                   resetn,

    mem_wb_if.slave                mem_wb,

    input  logic                   wb_allowin,   // Consumer takes the item
    output logic                   wb_valid,
    output logic                   wb_rf_we,
    output logic [`BE_RADDR_W-1:0] wb_rf_waddr,
    output logic [`BE_XLEN-1:0]    wb_rf_wdata,
    output logic [`BE_XLEN-1:0]    wb_pc
);

    logic            valid_r;
    be_pkg::mem_wb_t bus_r;

    assign mem_wb.allowin = ~valid_r | wb_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_r <= 1'b0;
        end else if (mem_wb.allowin) begin
            valid_r <= mem_wb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb.valid && mem_wb.allowin) begin
            bus_r <= mem_wb.data;
        end
    end

    assign wb_valid    = valid_r;
    assign wb_rf_we    = bus_r.rf_we & valid_r;
    assign wb_rf_waddr = bus_r.rf_waddr;
    assign wb_rf_wdata = bus_r.rf_wdata;
    assign wb_pc       = bus_r.pc;

endmodule

/* src/data_sram.sv */
`timescale 1ns/1ps
`include "be_config.svh"

module data_sram (
    input  logic     clk,
    dsram_if.memory  dsram
);

    localparam int DEPTH = 1 << `BE_DSRAM_AW;

    logic [`BE_XLEN-1:0] mem [0:DEPTH-1];
    logic [`BE_XLEN-1:0] rdata_r;

    // Read data holds until the next enabled load
    always_ff @(posedge clk) begin
        if (dsram.en) begin
            if (dsram.we) begin
                mem[dsram.addr] <= dsram.wdata;
            end else begin
                rdata_r <= mem[dsram.addr];
            end
        end
    end

    assign dsram.rdata = rdata_r;

endmodule

/* src/backend_top.sv */
`timescale 1ns/1ps
`include "be_config.svh"

module backend_top (
    input  logic                   clk,
    input  logic                   resetn,

    // Issue side
    input  logic                   in_valid,
    output logic                   in_allowin,
    input  logic [`BE_ALU_OPS-1:0] in_alu_op,
    input  logic                   in_res_from_mem,
    input  logic [`BE_XLEN-1:0]    in_src1,
    input  logic [`BE_XLEN-1:0]    in_src2,
    input  logic                   in_mem_we,
    input  logic                   in_rf_we,
    input  logic [`BE_RADDR_W-1:0] in_rf_waddr,
    input  logic [`BE_XLEN-1:0]    in_rkd_value,
    input  logic [`BE_XLEN-1:0]    in_pc,

    // Writeback side
    input  logic                   wb_allowin,
    output logic                   wb_valid,
    output logic                   wb_rf_we,
    output logic [`BE_RADDR_W-1:0] wb_rf_waddr,
    output logic [`BE_XLEN-1:0]    wb_rf_wdata,
    output logic [`BE_XLEN-1:0]    wb_pc
);

    be_pkg::issue_t issue;

    assign issue.alu_op       = in_alu_op;
    assign issue.res_from_mem = in_res_from_mem;
    assign issue.src1         = in_src1;
    assign issue.src2         = in_src2;
    assign issue.mem_we       = in_mem_we;
    assign issue.rf_we        = in_rf_we;
    assign issue.rf_waddr     = in_rf_waddr;
    assign issue.rkd_value    = in_rkd_value;
    assign issue.pc           = in_pc;

    ex_mem_if i_ex_mem ();
    mem_wb_if i_mem_wb ();
    dsram_if  i_dsram ();

    ex_stage i_ex_stage (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_bus     (issue),
        .ex_mem     (i_ex_mem.master),
        .dsram      (i_dsram.request)
    );

    mem_stage i_mem_stage (
        .clk    (clk),
        .resetn (resetn),
        .ex_mem (i_ex_mem.slave),
        .dsram  (i_dsram.rd),
        .mem_wb (i_mem_wb.master)
    );

    wb_stage i_wb_stage (
        .clk         (clk),
        .resetn      (resetn),
        .mem_wb      (i_mem_wb.slave),
        .wb_allowin  (wb_allowin),
        .wb_valid    (wb_valid),
        .wb_rf_we    (wb_rf_we),
        .wb_rf_waddr (wb_rf_waddr),
        .wb_rf_wdata (wb_rf_wdata),
        .wb_pc       (wb_pc)
    );

    data_sram i_data_sram (
        .clk   (clk),
        .dsram (i_dsram.memory)
    );

endmodule

/* tb/backend_tb.sv */
`timescale 1ns/1ps
`include "be_config.svh"

module backend_tb;

    localparam int ALU_REPEAT  = 8;
    localparam int MEM_N       = 16;
    localparam int BP_N        = 60;
    localparam int BURST_N     = 16;
    localparam int INSTR_TOTAL = `BE_ALU_OPS * ALU_REPEAT + 2 * MEM_N + 2 + BP_N + BURST_N;
    localparam int TIMEOUT_CYCLES = 10 * INSTR_TOTAL;   // About ten cycles per instruction

    logic                   clk = 1'b0;
    logic                   resetn;
    logic                   in_valid;
    logic                   in_allowin;
    logic [`BE_ALU_OPS-1:0] in_alu_op;
    logic                   in_res_from_mem;
    logic [`BE_XLEN-1:0]    in_src1;
    logic [`BE_XLEN-1:0]    in_src2;
    logic                   in_mem_we;
    logic                   in_rf_we;
    logic [`BE_RADDR_W-1:0] in_rf_waddr;
    logic [`BE_XLEN-1:0]    in_rkd_value;
    logic [`BE_XLEN-1:0]    in_pc;
    logic                   wb_allowin = 1'b1;
    logic                   wb_valid;
    logic                   wb_rf_we;
    logic [`BE_RADDR_W-1:0] wb_rf_waddr;
    logic [`BE_XLEN-1:0]    wb_rf_wdata;
    logic [`BE_XLEN-1:0]    wb_pc;

    be_pkg::mem_wb_t     exp_q[$];
    be_pkg::mem_wb_t     got_item;
    be_pkg::mem_wb_t     exp_item;
    logic [`BE_XLEN-1:0] shadow [0:(1 << `BE_DSRAM_AW)-1];   // Data RAM model
    logic [`BE_XLEN-1:0] mem_a [0:MEM_N-1];
    logic [`BE_XLEN-1:0] mem_b [0:MEM_N-1];
    logic [31:0]         rnd_state = 32'd71477;
    logic [31:0]         bp_state  = 32'd71477;
    logic                bp_on     = 1'b0;
    logic [`BE_XLEN-1:0] next_pc   = 32'h1c00_0000;
    int                  cyc = 0;
    int                  accepted = 0;
    int                  taken = 0;
    int                  gaps = 0;
    int                  last_take_cyc = -10;

    backend_top i_backend_top (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d items still expected", cyc, exp_q.size());
            $display("Test failed");
            $fatal(1);
        end
    end

    // Consumer stalls at random while enabled
    always @(posedge clk) begin
        #1;
        bp_state = lcg_step(bp_state);
        wb_allowin = bp_on ? bp_state[16] : 1'b1;
    end

    always @(negedge clk) begin
        if (resetn) begin
            if (accepted - taken == 3 && !wb_allowin) begin
                check_bit("in_allowin", in_allowin, 1'b0);   // All three stages full
            end
            if (wb_valid && wb_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("Writeback item with pc %h arrived but none was expected", wb_pc);
                    $display("Test failed");
                    $fatal(1);
                end else begin
                    got_item.rf_we    = wb_rf_we;
                    got_item.rf_waddr = wb_rf_waddr;
                    got_item.rf_wdata = wb_rf_wdata;
                    got_item.pc       = wb_pc;
                    exp_item = exp_q.pop_front();
                    check_wb(got_item, exp_item);
                    if (cyc != last_take_cyc + 1) begin
                        gaps = gaps + 1;
                    end
                    last_take_cyc = cyc;
                    taken = taken + 1;
                end
            end
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        rnd_state = lcg_step(rnd_state);
        hi = rnd_state;
        rnd_state = lcg_step(rnd_state);
        return {hi[31:16], rnd_state[31:16]};   // Upper halves only
    endfunction

    function automatic logic [`BE_XLEN-1:0] alu_ref(input be_pkg::alu_op_t op,
                                                    input logic [`BE_XLEN-1:0] a,
                                                    input logic [`BE_XLEN-1:0] b);
        logic [`BE_XLEN-1:0] r;
        logic [4:0]          sh;
        sh = b[4:0];
        r  = '0;
        if (op[be_pkg::OP_ADD])       r = a + b;
        else if (op[be_pkg::OP_SUB])  r = a - b;
        else if (op[be_pkg::OP_SLT])  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        else if (op[be_pkg::OP_SLTU]) r = (a < b) ? 32'd1 : 32'd0;
        else if (op[be_pkg::OP_AND])  r = a & b;
        else if (op[be_pkg::OP_NOR])  r = ~(a | b);
        else if (op[be_pkg::OP_OR])   r = a | b;
        else if (op[be_pkg::OP_XOR])  r = a ^ b;
        else if (op[be_pkg::OP_SLL])  r = a << sh;
        else if (op[be_pkg::OP_SRL])  r = a >> sh;
        else if (op[be_pkg::OP_SRA])  r = $signed(a) >>> sh;
        else if (op[be_pkg::OP_LUI])  r = b;
        return r;
    endfunction

    function automatic be_pkg::issue_t make_instr(input be_pkg::alu_op_e op, input logic load,
                                                  input logic store,
                                                  input logic [`BE_XLEN-1:0] a,
                                                  input logic [`BE_XLEN-1:0] b,
                                                  input logic we,
                                                  input logic [`BE_RADDR_W-1:0] waddr,
                                                  input logic [`BE_XLEN-1:0] rkd);
        be_pkg::issue_t ins;
        ins.alu_op       = be_pkg::alu_op_t'(1) << op;
        ins.res_from_mem = load;
        ins.src1         = a;
        ins.src2         = b;
        ins.mem_we       = store;
        ins.rf_we        = we;
        ins.rf_waddr     = waddr;
        ins.rkd_value    = rkd;
        ins.pc           = next_pc;
        next_pc = next_pc + 32'd4;
        return ins;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_wb(input be_pkg::mem_wb_t got, input be_pkg::mem_wb_t exp);
        string               name;
        logic [`BE_XLEN-1:0] g;
        logic [`BE_XLEN-1:0] e;
        name = "";
        if (got.rf_we !== exp.rf_we) begin
            name = "wb_rf_we";
            g = 32'(got.rf_we);
            e = 32'(exp.rf_we);
        end else if (got.rf_waddr !== exp.rf_waddr) begin
            name = "wb_rf_waddr";
            g = 32'(got.rf_waddr);
            e = 32'(exp.rf_waddr);
        end else if (got.rf_wdata !== exp.rf_wdata) begin
            name = "wb_rf_wdata";
            g = got.rf_wdata;
            e = exp.rf_wdata;
        end else if (got.pc !== exp.pc) begin
            name = "wb_pc";
            g = got.pc;
            e = exp.pc;
        end
        if (name != "") begin
            $display("ERROR %s: got %h expected %h (expected pc %h)", name, g, e, exp.pc);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic issue_instr(input be_pkg::issue_t ins);
        be_pkg::mem_wb_t                exp;
        logic [`BE_XLEN-1:0]            res;
        logic [`BE_DSRAM_AW-1:0]        idx;
        res = alu_ref(ins.alu_op, ins.src1, ins.src2);
        idx = res[`BE_DSRAM_AW+1:2];   // Word index from the address
        exp.rf_we    = ins.rf_we;
        exp.rf_waddr = ins.rf_waddr;
        exp.rf_wdata = ins.res_from_mem ? shadow[idx] : res;
        exp.pc       = ins.pc;
        if (ins.mem_we) begin
            shadow[idx] = ins.rkd_value;
        end
        exp_q.push_back(exp);
        in_alu_op       = ins.alu_op;
        in_res_from_mem = ins.res_from_mem;
        in_src1         = ins.src1;
        in_src2         = ins.src2;
        in_mem_we       = ins.mem_we;
        in_rf_we        = ins.rf_we;
        in_rf_waddr     = ins.rf_waddr;
        in_rkd_value    = ins.rkd_value;
        in_pc           = ins.pc;
        in_valid        = 1'b1;
        @(negedge clk);
        while (!in_allowin) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        accepted = accepted + 1;
        in_valid = 1'b0;
    endtask

    task automatic drain_pipe();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic run_alu_ops();
        logic [`BE_XLEN-1:0] w;
        int                  k;
        int                  n;
        for (k = 0; k < `BE_ALU_OPS; k++) begin
            for (n = 0; n < ALU_REPEAT; n++) begin
                w = rand_word();
                issue_instr(make_instr(be_pkg::alu_op_e'(k), 1'b0, 1'b0, rand_word(),
                                       rand_word(), 1'b1, w[4:0], 32'h0));
            end
        end
        drain_pipe();
    endtask

    task automatic run_load_store();
        logic [`BE_XLEN-1:0] w;
        int                  n;
        // Last word, loaded again after the batch
        issue_instr(make_instr(be_pkg::OP_ADD, 1'b0, 1'b1, 32'h0000_03fc, 32'h0, 1'b0,
                               5'd0, rand_word()));
        for (n = 0; n < MEM_N; n++) begin
            mem_a[n] = rand_word();
            mem_b[n] = rand_word() & 32'h0000_0ffc;
            issue_instr(make_instr(be_pkg::OP_ADD, 1'b0, 1'b1, mem_a[n], mem_b[n], 1'b0,
                                   5'd0, rand_word()));
        end
        for (n = 0; n < MEM_N; n++) begin
            w = rand_word();
            issue_instr(make_instr(be_pkg::OP_ADD, 1'b1, 1'b0, mem_a[n], mem_b[n], 1'b1,
                                   w[4:0], 32'h0));
        end
        issue_instr(make_instr(be_pkg::OP_ADD, 1'b1, 1'b0, 32'h0000_03fc, 32'h0, 1'b1,
                               5'd7, 32'h0));
        drain_pipe();
    endtask

    task automatic run_backpressure();
        logic [`BE_XLEN-1:0] r;
        int                  kind;
        int                  j;
        int                  n;
        @(negedge clk);
        bp_on = 1'b1;
        @(posedge clk);
        #1;
        for (n = 0; n < BP_N; n++) begin
            r = rand_word();
            kind = r % 3;
            j = r % MEM_N;
            if (kind == 0) begin
                issue_instr(make_instr(be_pkg::alu_op_e'(r % `BE_ALU_OPS), 1'b0, 1'b0,
                                       rand_word(), rand_word(), 1'b1, r[12:8], 32'h0));
            end else if (kind == 1) begin
                issue_instr(make_instr(be_pkg::OP_ADD, 1'b1, 1'b0, mem_a[j], mem_b[j], 1'b1,
                                       r[12:8], 32'h0));
            end else begin
                issue_instr(make_instr(be_pkg::OP_ADD, 1'b0, 1'b1, mem_a[j], mem_b[j], 1'b0,
                                       5'd0, rand_word()));
            end
        end
        @(negedge clk);
        bp_on = 1'b0;
        @(posedge clk);
        #1;
        drain_pipe();
    endtask

    task automatic run_burst();
        logic [`BE_XLEN-1:0] w;
        int                  gaps_before;
        int                  n;
        gaps_before = gaps;
        for (n = 0; n < BURST_N; n++) begin
            w = rand_word();
            issue_instr(make_instr(be_pkg::OP_XOR, 1'b0, 1'b0, rand_word(), rand_word(),
                                   n[0], w[4:0], 32'h0));   // rf_we off on even items
        end
        drain_pipe();
        if (gaps - gaps_before != 1) begin
            $display("Back-to-back burst did not return one writeback item per cycle");
            $display("Test failed");
            $fatal(1);
        end
    endtask

    initial begin
        resetn          = 1'b0;
        in_valid        = 1'b0;
        in_alu_op       = '0;
        in_res_from_mem = 1'b0;
        in_src1         = '0;
        in_src2         = '0;
        in_mem_we       = 1'b0;
        in_rf_we        = 1'b0;
        in_rf_waddr     = '0;
        in_rkd_value    = '0;
        in_pc           = '0;
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        check_bit("in_allowin", in_allowin, 1'b1);
        check_bit("wb_valid", wb_valid, 1'b0);
        run_alu_ops();
        run_load_store();
        run_backpressure();
        run_burst();
        if (exp_q.size() == 0 && accepted == taken) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("%0d writeback items never arrived", exp_q.size());
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

/* files.f */
+incdir+src
src/be_pkg.sv
src/ex_mem_if.sv
src/mem_wb_if.sv
src/dsram_if.sv
src/alu.sv
src/ex_stage.sv
src/mem_stage.sv
src/wb_stage.sv
src/data_sram.sv
src/backend_top.sv
tb/backend_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module backend_tb -f files.f -o backend_sim \
    && ./obj_dir/backend_sim \
    || exit 1
